/* rtl/pet_spi_cfg.svh */
`ifndef PET_SPI_CFG_SVH
`define PET_SPI_CFG_SVH

// Flops between each bus pin and the logic that uses it
`define PET_SYNC_STAGES 2

// RAM size in bytes, a power of two
// Addresses above this alias onto the low bits
`define PET_MEM_WORDS 1024

`endif

/* rtl/pet_spi_pkg.sv */
// Shared types for the PET SPI-to-memory bridge
package pet_spi_pkg;

    // One byte as it crosses the SPI bus
    typedef logic [7:0] pet_byte_t;

    // 13-bit RAM address, 5 bits from the command plus 8 from the address byte
    typedef logic [12:0] pet_addr_t;

    // Command opcodes in the top three bits of the first byte of a frame
    typedef enum logic [2:0] {
        OP_READ       = 3'd1,  // Command, addr lo, then one byte clocked out
        OP_WRITE      = 3'd2,  // Command, addr lo, data byte
        OP_WRITE_NEXT = 3'd3   // Command, then len+1 data bytes
    } pet_op_e;
    // Any other value makes the decoder sit out the rest of the frame

    // Access view of the command byte, used by READ and WRITE
    typedef struct packed {
        pet_op_e    op;       // Bits 7:5
        logic [4:0] addr_hi;  // Bits 4:0, upper address bits
    } pet_access_t;

    // Burst view of the command byte, used by WRITE_NEXT
    typedef struct packed {
        pet_op_e    op;   // Bits 7:5, same position as in the access view
        logic [4:0] len;  // Data bytes that follow, minus one
    } pet_burst_t;

    // One command byte, read through whichever view the opcode calls for
    typedef union packed {
        pet_access_t access;
        pet_burst_t  burst;
    } pet_cmd_u;

endpackage

/* rtl/spi_byte_if.sv */
`timescale 1ns/100ps

// Byte-level link between the SPI shifter and the command decoder
interface spi_byte_if;

    pet_spi_pkg::pet_byte_t rx_byte;       // Last complete byte from SDI
    logic                   rx_strobe;     // One clock, rx_byte just updated
    logic                   frame_start;   // One clock, chip select went low
    logic                   frame_active;  // High while chip select is low
    pet_spi_pkg::pet_byte_t tx_byte;       // Next byte to shift out on SDO

    // Shifter side
    modport peripheral (
        output rx_byte,
        output rx_strobe,
        output frame_start,
        output frame_active,
        input  tx_byte
    );

    // Decoder side
    modport decoder (
        input  rx_byte,
        input  rx_strobe,
        input  frame_start,
        input  frame_active,
        output tx_byte
    );

endinterface

/* rtl/mem_bus_if.sv */
`timescale 1ns/100ps

// Request path from the command decoder to the RAM
interface mem_bus_if;

    pet_spi_pkg::pet_addr_t addr;   // Byte address, RAM aliases the top bits
    pet_spi_pkg::pet_byte_t wdata;  // Write data, valid with we
    logic                   we;     // One clock write strobe
    logic                   re;     // One clock read strobe
    pet_spi_pkg::pet_byte_t rdata;  // Read data, valid the clock after re

    modport master (
        output addr,
        output wdata,
        output we,
        output re,
        input  rdata
    );

    modport ram (
        input  addr,
        input  wdata,
        input  we,
        input  re,
        output rdata
    );

endinterface

/* rtl/spi_peripheral.sv */
`timescale 1ns/100ps
`include "pet_spi_cfg.svh"

// SPI mode 0 shifter running off the system clock
// SDI sampled on rising SCK, SDO updated on falling SCK
module spi_peripheral (
    input  logic           spi_cs_ni,  // System clock
    input  logic           spi_sck_i,  // Async reset, active low
    input  logic           bus_csn_i,  // SPI chip select, active low
    input  logic           bus_sck_i,  // SPI clock, idles low
    input  logic           bus_sdi_i,  // SPI data from host
    output logic           bus_sdo_o,  // SPI data to host
    spi_byte_if.peripheral byte_if
);

    localparam int SYNC = `PET_SYNC_STAGES;

    // Synchronizer chains, bit 0 nearest the pin
    logic [SYNC-1:0] csn_sync;
    logic [SYNC-1:0] sck_sync;
    logic [SYNC-1:0] sdi_sync;

    logic csn_s;  // Synchronized pins
    logic sck_s;
    logic sdi_s;

    logic csn_q;  // Previous synced level, for edge detect
    logic sck_q;

    logic sck_rise;
    logic sck_fall;
    logic cs_fall;

    logic [2:0] bit_cnt;   // Bits already received in this byte
    logic [6:0] rx_shift;  // Bits received so far, MSB first
    logic [6:0] tx_shift;  // Bits still to send after the one on SDO

    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            csn_sync <= '1;  // Bus idle, chip select high
            sck_sync <= '0;
            sdi_sync <= '0;
        end else begin
            csn_sync <= {csn_sync[SYNC-2:0], bus_csn_i};
            sck_sync <= {sck_sync[SYNC-2:0], bus_sck_i};
            sdi_sync <= {sdi_sync[SYNC-2:0], bus_sdi_i};
        end
    end

    assign csn_s = csn_sync[SYNC-1];
    assign sck_s = sck_sync[SYNC-1];
    assign sdi_s = sdi_sync[SYNC-1];

    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            csn_q <= 1'b1;
            sck_q <= 1'b0;
        end else begin
            csn_q <= csn_s;
            sck_q <= sck_s;
        end
    end

    // SCK edges only count inside a frame
    assign sck_rise = sck_s & ~sck_q & ~csn_s;
    assign sck_fall = ~sck_s & sck_q & ~csn_s;
    assign cs_fall  = csn_q & ~csn_s;

    // Bit counter and frame status
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            bit_cnt              <= '0;
            byte_if.rx_strobe    <= 1'b0;
            byte_if.frame_start  <= 1'b0;
            byte_if.frame_active <= 1'b0;
        end else begin
            byte_if.rx_strobe    <= sck_rise && (bit_cnt == 3'd7);  // Eighth bit in
            byte_if.frame_start  <= cs_fall;
            byte_if.frame_active <= ~csn_s;
            if (csn_s) begin
                bit_cnt <= '0;  // Aborted byte is dropped
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;  // Wraps to zero after bit 7
            end
        end
    end

    // Receive shifter
    always_ff @(posedge spi_cs_ni) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[5:0], sdi_s};
            if (bit_cnt == 3'd7) begin
                byte_if.rx_byte <= {rx_shift, sdi_s};
            end
        end
    end

    // Transmit shifter
    // The next byte is picked up on the falling SCK that follows the last
    // rising SCK of the previous byte, so its MSB is on SDO before bit 0
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            tx_shift  <= '0;
            bus_sdo_o <= 1'b0;
        end else if (csn_s) begin
            tx_shift  <= '0;  // Deselected, drive zero
            bus_sdo_o <= 1'b0;
        end else if (cs_fall || (sck_fall && bit_cnt == 3'd0)) begin
            tx_shift  <= byte_if.tx_byte[6:0];
            bus_sdo_o <= byte_if.tx_byte[7];  // MSB first
        end else if (sck_fall) begin
            tx_shift  <= {tx_shift[5:0], 1'b0};
            bus_sdo_o <= tx_shift[6];
        end
    end

endmodule

/* rtl/spi_cmd_decoder.sv */
`timescale 1ns/100ps

// Frame FSM for the command byte, address byte and data in or out
module spi_cmd_decoder (
    input  logic        spi_cs_ni,  // System clock
    input  logic        spi_sck_i,  // Asynchronous active-low reset
    spi_byte_if.decoder byte_if,
    mem_bus_if.master   mem_if
);

    typedef enum logic [2:0] {
        ST_IDLE,        // Waiting for chip select
        ST_CMD,         // Expecting the command byte
        ST_ADDR_LO,     // Expecting the low address byte
        ST_READ_OUT,    // Read issued, data goes out in the next byte
        ST_WRITE_DATA,  // Expecting the single write byte
        ST_BURST_DATA,  // Expecting WRITE_NEXT data bytes
        ST_IGNORE       // Rest of frame is discarded
    } state_e;

    state_e                 state_q;
    pet_spi_pkg::pet_cmd_u  cmd_in;       // Incoming byte seen as a command
    pet_spi_pkg::pet_cmd_u  cmd_q;        // Held command for the address byte
    pet_spi_pkg::pet_addr_t addr_q;       // Last address read or written
    pet_spi_pkg::pet_byte_t wdata_q;
    logic [4:0]             burst_cnt_q;  // Burst bytes left minus one
    logic                   we_q;
    logic                   re_q;
    logic                   rd_ready_q;   // rdata holds the byte for read-out

    assign cmd_in = byte_if.rx_byte;

    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            state_q     <= ST_IDLE;
            addr_q      <= '0;
            burst_cnt_q <= '0;
            we_q        <= 1'b0;
            re_q        <= 1'b0;
        end else begin
            we_q <= 1'b0;  // Strobes last one clock
            re_q <= 1'b0;
            if (!byte_if.frame_active) begin
                state_q <= ST_IDLE;  // CS high ends any frame
            end else if (byte_if.frame_start) begin
                state_q <= ST_CMD;
            end else if (byte_if.rx_strobe) begin
                case (state_q)
                    ST_CMD: begin
                        case (cmd_in.access.op)
                            pet_spi_pkg::OP_READ,
                            pet_spi_pkg::OP_WRITE: state_q <= ST_ADDR_LO;
                            pet_spi_pkg::OP_WRITE_NEXT: begin
                                burst_cnt_q <= cmd_in.burst.len;  // Length view
                                state_q     <= ST_BURST_DATA;
                            end
                            default: state_q <= ST_IGNORE;  // Unknown opcode
                        endcase
                    end
                    ST_ADDR_LO: begin
                        addr_q <= {cmd_q.access.addr_hi, byte_if.rx_byte};
                        if (cmd_q.access.op == pet_spi_pkg::OP_READ) begin
                            re_q    <= 1'b1;
                            state_q <= ST_READ_OUT;
                        end else begin
                            state_q <= ST_WRITE_DATA;
                        end
                    end
                    ST_WRITE_DATA: begin
                        we_q    <= 1'b1;
                        state_q <= ST_IGNORE;  // One byte per WRITE
                    end
                    ST_BURST_DATA: begin
                        addr_q      <= addr_q + 13'd1;  // Step before each byte
                        we_q        <= 1'b1;
                        burst_cnt_q <= burst_cnt_q - 5'd1;
                        if (burst_cnt_q == 5'd0) begin
                            state_q <= ST_IGNORE;
                        end
                    end
                    ST_READ_OUT: state_q <= ST_IGNORE;  // Read byte has gone out
                    default: state_q <= state_q;  // Idle and ignore wait for CS
                endcase
            end
        end
    end

    // Command byte and write data registers
    always_ff @(posedge spi_cs_ni) begin
        if (byte_if.rx_strobe && state_q == ST_CMD) begin
            cmd_q <= cmd_in;
        end
        if (byte_if.rx_strobe) begin
            wdata_q <= byte_if.rx_byte;
        end
    end

    // rdata becomes valid the clock after re and stays until the next read
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            rd_ready_q <= 1'b0;
        end else if (re_q) begin
            rd_ready_q <= 1'b1;
        end else if (state_q != ST_READ_OUT) begin
            rd_ready_q <= 1'b0;
        end
    end

    // Only the read-out byte carries data and all others shift out zero
    assign byte_if.tx_byte = (state_q == ST_READ_OUT && rd_ready_q) ? mem_if.rdata : '0;

    assign mem_if.addr  = addr_q;  // Updated in the same clock as we or re
    assign mem_if.wdata = wdata_q;
    assign mem_if.we    = we_q;
    assign mem_if.re    = re_q;

endmodule

/* rtl/pet_mem_port.sv */
`timescale 1ns/100ps
`include "pet_spi_cfg.svh"

// Single-port byte RAM with a registered read
module pet_mem_port (
    input  logic    spi_cs_ni,  // System clock
    input  logic    spi_sck_i,  // Asynchronous active-low reset
    mem_bus_if.ram  mem_if
);

    localparam int WORDS = `PET_MEM_WORDS;
    localparam int AW    = $clog2(WORDS);

    pet_spi_pkg::pet_byte_t mem [WORDS];  // PET RAM bytes
    logic [AW-1:0]          idx;          // Upper address bits alias

    assign idx = mem_if.addr[AW-1:0];

    always_ff @(posedge spi_cs_ni) begin
        if (mem_if.we) begin
            mem[idx] <= mem_if.wdata;
        end
    end

    // Read data held until the next re
    always_ff @(posedge spi_cs_ni or negedge spi_sck_i) begin
        if (!spi_sck_i) begin
            mem_if.rdata <= '0;
        end else if (mem_if.re) begin
            mem_if.rdata <= mem[idx];
        end
    end

endmodule

/* rtl/pet_spi_bridge.sv */
`timescale 1ns/100ps

// SPI mode 0 bridge into the PET RAM
module pet_spi_bridge (
    input  logic spi_cs_ni,  // System clock
    input  logic spi_sck_i,  // Async reset, active low
    input  logic bus_csn_i,
    input  logic bus_sck_i,
    input  logic bus_sdi_i,
    output logic bus_sdo_o
);

    spi_byte_if byte_if ();  // Shifter to decoder
    mem_bus_if  mem_if ();   // Decoder to RAM

    spi_peripheral u_spi_peripheral (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .bus_csn_i (bus_csn_i),
        .bus_sck_i (bus_sck_i),
        .bus_sdi_i (bus_sdi_i),
        .bus_sdo_o (bus_sdo_o),
        .byte_if   (byte_if.peripheral)
    );

    spi_cmd_decoder u_spi_cmd_decoder (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .byte_if   (byte_if.decoder),
        .mem_if    (mem_if.master)
    );

    pet_mem_port u_pet_mem_port (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .mem_if    (mem_if.ram)
    );

endmodule

/* testbench/pet_spi_props.sv */
`timescale 1ns/100ps

// Protocol checks on the links inside the bridge
module pet_spi_props (
    input logic spi_cs_ni,       // System clock
    input logic spi_sck_i,       // Active-low reset
    input logic rx_strobe_i,
    input logic frame_active_i,
    input logic we_i,
    input logic re_i
);

    int unsigned assert_fails = 0;  // Assertion failures so far

    // A byte arrives at most once per clock pair
    rx_strobe_pulse: assert property (@(posedge spi_cs_ni) disable iff (!spi_sck_i)
        rx_strobe_i |=> !rx_strobe_i)
        else begin
            $error("rx_strobe held high for more than one clock");
            assert_fails++;
        end

    we_re_exclusive: assert property (@(posedge spi_cs_ni) disable iff (!spi_sck_i)
        !(we_i && re_i))
        else begin
            $error("we and re asserted in the same clock");
            assert_fails++;
        end

    // Writes only come from a frame still selected
    we_in_frame: assert property (@(posedge spi_cs_ni) disable iff (!spi_sck_i)
        we_i |-> frame_active_i)
        else begin
            $error("we asserted outside a frame");
            assert_fails++;
        end

endmodule

bind pet_spi_bridge pet_spi_props u_pet_spi_props (
    .spi_cs_ni      (spi_cs_ni),
    .spi_sck_i      (spi_sck_i),
    .rx_strobe_i    (byte_if.rx_strobe),
    .frame_active_i (byte_if.frame_active),
    .we_i           (mem_if.we),
    .re_i           (mem_if.re)
);

/* testbench/tb_pet_spi.sv */
`timescale 1ns/100ps
`include "pet_spi_cfg.svh"

// Directed testbench for the SPI-to-memory bridge, host side modelled in tasks
module tb_pet_spi;

    localparam int HALF_CLKS = 5;                         // System clocks per SCK half period
    localparam int GAP_CLKS  = 2 * (`PET_SYNC_STAGES + 2); // CS high time between frames
    localparam int RST_WAIT  = `PET_SYNC_STAGES + 16;

    logic spi_cs_ni;  // System clock
    logic spi_sck_i;  // Reset, active low
    logic bus_csn_i;
    logic bus_sck_i;
    logic bus_sdi_i;
    logic bus_sdo_o;

    pet_spi_pkg::pet_byte_t sb_mem [`PET_MEM_WORDS];  // Expected RAM contents
    pet_spi_pkg::pet_addr_t last_addr;                 // Model of the held address
    int unsigned errors;
    int unsigned test_errors;
    int unsigned checks;
    int unsigned tests_run;

    pet_spi_bridge DUT (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .bus_csn_i (bus_csn_i),
        .bus_sck_i (bus_sck_i),
        .bus_sdi_i (bus_sdi_i),
        .bus_sdo_o (bus_sdo_o)
    );

    always #5 spi_cs_ni = ~spi_cs_ni;  // 10 ns period

    task automatic idle_clocks(input int n);
        repeat (n) @(negedge spi_cs_ni);
    endtask

    // RAM byte selected by an address, upper bits alias
    function automatic int mem_index(input pet_spi_pkg::pet_addr_t addr);
        return int'(addr) % `PET_MEM_WORDS;
    endfunction

    // Opcode in bits 7:5, address high bits or burst length below
    function automatic pet_spi_pkg::pet_byte_t make_cmd(input logic [2:0] op,
                                                        input logic [4:0] low5);
        return {op, low5};
    endfunction

    task automatic check_byte(input string name, input pet_spi_pkg::pet_byte_t expected,
                              input pet_spi_pkg::pet_byte_t actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected %02h, actual %02h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // Mode 0, MSB first; host samples SDO just before SCK rises
    task automatic shift_byte(input pet_spi_pkg::pet_byte_t tx, input int nbits,
                              output pet_spi_pkg::pet_byte_t rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--) begin
            bus_sdi_i = tx[i];
            idle_clocks(HALF_CLKS);
            rx[i] = bus_sdo_o;
            bus_sck_i = 1'b1;
            idle_clocks(HALF_CLKS);
            bus_sck_i = 1'b0;
        end
    endtask

    task automatic end_frame();
        bus_sdi_i = 1'b0;
        idle_clocks(HALF_CLKS);
        bus_csn_i = 1'b1;
        idle_clocks(GAP_CLKS);
    endtask

    // Three-byte frame, the last byte may stop after fewer bits
    task automatic send_frame(input pet_spi_pkg::pet_byte_t cmd,
                              input pet_spi_pkg::pet_byte_t lo,
                              input pet_spi_pkg::pet_byte_t data, input int data_bits,
                              output pet_spi_pkg::pet_byte_t rx0,
                              output pet_spi_pkg::pet_byte_t rx1,
                              output pet_spi_pkg::pet_byte_t rx2);
        bus_csn_i = 1'b0;
        shift_byte(cmd, 8, rx0);
        shift_byte(lo, 8, rx1);
        shift_byte(data, data_bits, rx2);
        end_frame();
    endtask

    task automatic do_write(input pet_spi_pkg::pet_addr_t addr,
                            input pet_spi_pkg::pet_byte_t data);
        pet_spi_pkg::pet_byte_t r0;
        pet_spi_pkg::pet_byte_t r1;
        pet_spi_pkg::pet_byte_t r2;
        send_frame(make_cmd(pet_spi_pkg::OP_WRITE, addr[12:8]), addr[7:0], data, 8,
                   r0, r1, r2);
        sb_mem[mem_index(addr)] = data;
        last_addr = addr;
    endtask

    // Data comes back in the third byte, the first two carry zero
    task automatic do_read(input pet_spi_pkg::pet_addr_t addr,
                           output pet_spi_pkg::pet_byte_t data,
                           output pet_spi_pkg::pet_byte_t lead0,
                           output pet_spi_pkg::pet_byte_t lead1);
        send_frame(make_cmd(pet_spi_pkg::OP_READ, addr[12:8]), addr[7:0], 8'h00, 8,
                   lead0, lead1, data);
        last_addr = addr;
    endtask

    task automatic do_write_next(input pet_spi_pkg::pet_byte_t data [$]);
        pet_spi_pkg::pet_byte_t rx;
        bus_csn_i = 1'b0;
        shift_byte(make_cmd(pet_spi_pkg::OP_WRITE_NEXT, 5'(data.size() - 1)), 8, rx);
        foreach (data[k]) begin
            shift_byte(data[k], 8, rx);
            last_addr = last_addr + 13'd1;  // Step comes before each byte
            sb_mem[mem_index(last_addr)] = data[k];
        end
        end_frame();
    endtask

    task automatic wait_reset_release(output logic ok);
        int n;
        n = 0;
        while (!(spi_sck_i === 1'b1 && bus_sdo_o === 1'b0) && n < RST_WAIT) begin
            @(negedge spi_cs_ni);
            n++;
        end
        ok = (spi_sck_i === 1'b1 && bus_sdo_o === 1'b0);
    endtask

    task automatic write_then_read();
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        do_write(13'h0123, 8'hA7);
        do_read(13'h0123, rd, l0, l1);
        check_byte("write_then_read", 8'hA7, rd);
        report_test("write_then_read");
    endtask

    task automatic random_write_alias();
        pet_spi_pkg::pet_addr_t addrs [20];
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        for (int i = 0; i < 20; i++) begin
            if (i < 10) begin
                addrs[i] = 13'($urandom);
            end else begin
                addrs[i] = addrs[i - 10] ^ 13'(`PET_MEM_WORDS);  // Same RAM byte, other alias
            end
            do_write(addrs[i], 8'($urandom));
        end
        for (int i = 0; i < 20; i++) begin
            do_read(addrs[i], rd, l0, l1);
            check_byte($sformatf("random_write_alias read %0d", i),
                       sb_mem[mem_index(addrs[i])], rd);
        end
        report_test("random_write_alias");
    endtask

    task automatic burst_after_write();
        pet_spi_pkg::pet_byte_t burst [$];
        pet_spi_pkg::pet_addr_t base;
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        base = 13'h1FFE;  // Burst runs over the top of the address space
        for (int k = 0; k < 4; k++) begin
            burst.push_back(8'($urandom));
        end
        do_write(base, 8'h6E);
        do_write_next(burst);
        for (int k = 0; k < 4; k++) begin
            do_read(base + 13'(k + 1), rd, l0, l1);
            check_byte($sformatf("burst_after_write byte %0d", k), burst[k], rd);
        end
        do_read(base, rd, l0, l1);
        check_byte("burst_after_write base", 8'h6E, rd);
        report_test("burst_after_write");
    endtask

    task automatic unknown_opcode_ignored();
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        pet_spi_pkg::pet_byte_t l2;
        do_write(13'h0456, 8'h5A);
        send_frame(make_cmd(3'd6, 5'h04), 8'h56, 8'hA5, 8, l0, l1, l2);
        do_read(13'h0456, rd, l0, l1);
        check_byte("unknown_opcode_ignored", sb_mem[mem_index(13'h0456)], rd);
        report_test("unknown_opcode_ignored");
    endtask

    task automatic abort_mid_byte();
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        pet_spi_pkg::pet_byte_t l2;
        do_write(13'h0789, 8'h3C);
        send_frame(make_cmd(pet_spi_pkg::OP_WRITE, 5'h07), 8'h89, 8'hC3, 4, l0, l1, l2);
        last_addr = 13'h0789;  // Address byte was complete before CS rose
        do_read(13'h0789, rd, l0, l1);
        check_byte("abort_mid_byte", 8'h3C, rd);
        report_test("abort_mid_byte");
    endtask

    task automatic read_leading_zeros();
        pet_spi_pkg::pet_byte_t rd;
        pet_spi_pkg::pet_byte_t l0;
        pet_spi_pkg::pet_byte_t l1;
        do_write(13'h0A0B, 8'hFF);  // All ones, so stray data would show
        do_read(13'h0A0B, rd, l0, l1);
        check_byte("read_leading_zeros cmd byte", 8'h00, l0);
        check_byte("read_leading_zeros addr byte", 8'h00, l1);
        check_byte("read_leading_zeros data", 8'hFF, rd);
        report_test("read_leading_zeros");
    endtask

    initial begin
        logic reset_ok;
        void'($urandom(32'he7fc));
        spi_cs_ni   = 1'b0;
        spi_sck_i   = 1'b0;  // Reset held from time zero
        bus_csn_i   = 1'b1;
        bus_sck_i   = 1'b0;
        bus_sdi_i   = 1'b0;
        last_addr   = '0;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        idle_clocks(8);
        spi_sck_i = 1'b1;
        wait_reset_release(reset_ok);
        if (!reset_ok) begin
            $display("timeout: bus_sdo_o did not settle low after reset release");
            $display("TEST FAILED");
        end else begin
            idle_clocks(GAP_CLKS);
            write_then_read();
            random_write_alias();
            burst_after_write();
            unknown_opcode_ignored();
            abort_mid_byte();
            read_leading_zeros();
            errors += DUT.u_pet_spi_props.assert_fails;
            $display("tests %0d, checks %0d, errors %0d (assertion failures %0d)",
                     tests_run, checks, errors, DUT.u_pet_spi_props.assert_fails);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+rtl
rtl/pet_spi_pkg.sv
rtl/spi_byte_if.sv
rtl/mem_bus_if.sv
rtl/spi_peripheral.sv
rtl/spi_cmd_decoder.sv
rtl/pet_mem_port.sv
rtl/pet_spi_bridge.sv
testbench/pet_spi_props.sv
testbench/tb_pet_spi.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_pet_spi -f tb.f

# The result is taken from the printed output, not the exit status
out=$(./obj_dir/Vtb_pet_spi +verilator+error+limit+100) || true
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
